// File: Makefile
# Verilator build and run for the strand selection stage

VERILATOR ?= verilator
TOP ?= strand_select_tb
RTL_TOP ?= strand_select_stage
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?=
PASS_TEXT ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the testbench printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) \
		source/instruction_format_pkg.sv source/strand_pkg.sv source/strand_fsm.sv \
		source/execute_hazard_detect.sv source/issue_arbiter.sv \
		source/strand_select_stage.sv

clean:
	rm -rf $(OBJ_DIR)

// File: source/execute_hazard_detect.sv
/*
 * Writeback conflict check for the execute merge point. Remembers recent
 * long-latency issues and blocks short-latency strands in the cycle whose
 * result would collide with the long-latency one.
 */
`timescale 1ns/1ps
`default_nettype none

module execute_hazard_detect
	import strand_pkg::*;
#(
	parameter int NUM_STRANDS = strand_pkg::NUM_STRANDS,
	parameter int LONG_GAP = 3
)
(
	input wire					clk,
	input wire					reset,
	input wire strand_oh_t		grant_i,
	input wire strand_oh_t		short_latency_i,
	input wire strand_oh_t		long_latency_i,
	output strand_oh_t			hazard_o
);

	// Bit n set means a long-latency issue n+1 cycles ago
	logic [LONG_GAP-1:0] long_issued;
	logic issued_now;

	assign issued_now = |(grant_i & long_latency_i);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			long_issued <= '0;
		else
			long_issued <= (long_issued << 1) | LONG_GAP'(issued_now);
	end

	// Short-latency strands would land on the long pipeline's result
	assign hazard_o = {NUM_STRANDS{long_issued[LONG_GAP-1]}} & short_latency_i;

endmodule

`default_nettype wire

// File: source/instruction_format_pkg.sv
/*
 * Instruction word encoding shared by the strand FSMs and the selection top.
 * Strided vector memory operations carry a marker in the top three bits
 * and a 12-bit stride in the low bits.
 */
`default_nettype none

package instruction_format_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [11:0] stride_t;

	localparam instr_t INSTR_NOP = '0;

	// Top three bits all set mark a strided vector load or store
	localparam logic [2:0] STRIDED_MARK = 3'b111;

	function automatic logic is_strided_op(input instr_t instr);
		return instr[31:29] == STRIDED_MARK;
	endfunction

	// Byte stride between consecutive lanes
	function automatic stride_t stride_of(input instr_t instr);
		return instr[11:0];
	endfunction

endpackage

`default_nettype wire

// File: source/issue_arbiter.sv
/*
 * Round-robin arbiter over the strands. Searches the request vector
 * starting at a rotating pointer and returns a one-hot grant; the
 * pointer moves past the winner after every grant.
 */
`timescale 1ns/1ps
`default_nettype none

module issue_arbiter
	import strand_pkg::*;
#(
	parameter int NUM_STRANDS = strand_pkg::NUM_STRANDS
)
(
	input wire					clk,
	input wire					reset,
	input wire strand_oh_t		request_i,
	output strand_oh_t			grant_o
);

	strand_idx_t rr_ptr;
	strand_idx_t grant_idx;
	logic grant_valid;

	always_comb
	begin
		int candidate;

		candidate = 0;
		grant_o = '0;
		grant_idx = rr_ptr;
		grant_valid = 1'b0;
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			candidate = (int'(rr_ptr) + i) % NUM_STRANDS;
			if (!grant_valid && request_i[candidate])
			begin
				grant_valid = 1'b1;
				grant_idx = strand_idx_t'(candidate);
			end
		end

		if (grant_valid)
			grant_o[grant_idx] = 1'b1;
	end

	// Lowest priority goes to the strand just served
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			rr_ptr <= '0;
		else if (grant_valid)
			rr_ptr <= strand_idx_t'((int'(grant_idx) + 1) % NUM_STRANDS);
	end

	grant_onehot_subset: assert property (
		@(posedge clk) disable iff (reset)
		$onehot0(grant_o) && ((grant_o & ~request_i) == '0))
		else $error("issue_arbiter: grant not one-hot or not requested");

endmodule

`default_nettype wire

// File: source/strand_fsm.sv
/*
 * Issue state machine of a single strand. Tracks whether the strand may
 * issue, steps strided vector operations through the lanes, waits out a
 * fixed stall after long-latency instructions and parks on a cache miss.
 */
`timescale 1ns/1ps
`default_nettype none

module strand_fsm
	import instruction_format_pkg::*;
	import strand_pkg::*;
#(
	parameter int LONG_STALL = 4
)
(
	input wire					clk,
	input wire					reset,

	// From fetch and the rollback unit
	input wire fetch_slot_t		fetch_i,
	input wire strand_ctrl_t	ctrl_i,

	// From the arbiter
	input wire					grant_i,

	output logic				ready_o,
	output logic				instruction_req_o,
	output lane_t				reg_lane_o,
	output offset_t				strided_offset_o
);

	localparam int STALL_W = $clog2(LONG_STALL + 1);
	localparam lane_t FIRST_LANE = '1;

	strand_state_t state;
	lane_t lane;
	offset_t offset;
	logic [STALL_W-1:0] stall_count;
	logic strided;
	logic last_issue;
	logic redirect;

	assign strided = is_strided_op(fetch_i.instruction);

	// A plain instruction issues once, a strided one finishes on lane 0
	assign last_issue = !strided || lane == '0;

	// Rollback, retry and suspend all override a grant in this cycle
	assign redirect = ctrl_i.rollback || ctrl_i.retry || ctrl_i.suspend;

	assign ready_o = fetch_i.valid && (state == STRAND_READY || state == STRAND_VECTOR);
	assign instruction_req_o = grant_i && last_issue && !redirect;
	assign reg_lane_o = lane;
	assign strided_offset_o = offset;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= STRAND_READY;
			lane <= FIRST_LANE;
			offset <= '0;
			stall_count <= '0;
		end
		else if (ctrl_i.rollback)
		begin
			// Restart the instruction from its first lane
			state <= STRAND_READY;
			lane <= FIRST_LANE;
			offset <= '0;
		end
		else if (ctrl_i.retry)
		begin
			// Pick the vector transfer up where it faulted
			state <= STRAND_READY;
			lane <= ctrl_i.rollback_lane;
			offset <= ctrl_i.rollback_offset;
		end
		else if (ctrl_i.suspend)
			state <= STRAND_SUSPENDED;
		else
		begin
			case (state)
				STRAND_READY, STRAND_VECTOR:
				begin
					if (grant_i)
					begin
						if (last_issue)
						begin
							lane <= FIRST_LANE;
							offset <= '0;
							if (fetch_i.long_latency)
							begin
								state <= STRAND_STALL;
								stall_count <= STALL_W'(LONG_STALL - 1);
							end
							else
								state <= STRAND_READY;
						end
						else
						begin
							// Next lane, next element address
							lane <= lane - 1'b1;
							offset <= offset + offset_t'(stride_of(fetch_i.instruction));
							state <= STRAND_VECTOR;
						end
					end
				end

				STRAND_STALL:
				begin
					if (stall_count == '0)
						state <= STRAND_READY;
					else
						stall_count <= stall_count - 1'b1;
				end

				STRAND_SUSPENDED:
				begin
					if (ctrl_i.resume)
						state <= STRAND_READY;
				end

				default:
					state <= STRAND_READY;
			endcase
		end
	end

	// The arbiter only grants strands that reported ready
	grant_only_when_ready: assert property (
		@(posedge clk) disable iff (reset) grant_i |-> ready_o)
		else $error("strand_fsm: grant while strand not ready");

endmodule

`default_nettype wire

// File: source/strand_pkg.sv
/*
 * Strand level types for the selection stage: indices, lane and offset
 * widths, the per-strand FSM states and the structs that carry fetch
 * slots, rollback control and the issued instruction to decode.
 */
`default_nettype none

package strand_pkg;

	localparam int NUM_STRANDS = 4;

	typedef logic [$clog2(NUM_STRANDS)-1:0] strand_idx_t;
	typedef logic [NUM_STRANDS-1:0] strand_oh_t;

	// Lanes of a vector register issue from 15 down to 0
	typedef logic [3:0] lane_t;
	typedef logic [31:0] addr_t;
	typedef logic [31:0] offset_t;

	typedef enum logic [1:0] {
		STRAND_READY,
		STRAND_VECTOR,
		STRAND_STALL,
		STRAND_SUSPENDED
	} strand_state_t;

	// Next instruction of one strand as presented by fetch
	typedef struct packed {
		instruction_format_pkg::instr_t instruction;
		addr_t pc;
		logic valid;
		logic branch_predicted;
		logic long_latency;
	} fetch_slot_t;

	// Pulses from the rollback and memory units
	typedef struct packed {
		logic rollback;
		logic retry;
		logic suspend;
		logic resume;
		offset_t rollback_offset;
		lane_t rollback_lane;
	} strand_ctrl_t;

	typedef struct packed {
		addr_t pc;
		instruction_format_pkg::instr_t instruction;
		lane_t reg_lane;
		offset_t strided_offset;
		strand_idx_t strand;
		logic branch_predicted;
		logic long_latency;
	} issue_t;

endpackage

`default_nettype wire

// File: source/strand_select_stage.sv
/*
 * Strand selection stage of the vector pipeline. Every cycle one eligible
 * strand is chosen and its instruction is registered for decode, or a NOP
 * when none can go. Owns the strand FSMs, hazard detector and arbiter.
 */
`timescale 1ns/1ps
`default_nettype none

module strand_select_stage
	import instruction_format_pkg::*;
	import strand_pkg::*;
#(
	parameter int NUM_STRANDS = strand_pkg::NUM_STRANDS,
	parameter int LONG_STALL = 4,
	parameter int LONG_GAP = 3
)
(
	input wire					clk,
	input wire					reset,

	// From the control registers
	input wire strand_oh_t		strand_enable_i,

	// From fetch and the rollback unit
	input wire fetch_slot_t		fetch_i [NUM_STRANDS],
	input wire strand_ctrl_t	ctrl_i [NUM_STRANDS],

	// Back to fetch
	output strand_oh_t			instruction_req_o,

	// To decode
	output issue_t				issue_o
);

	localparam issue_t NOP_ISSUE = '{
		pc: '0,
		instruction: INSTR_NOP,
		reg_lane: '0,
		strided_offset: '0,
		strand: '0,
		branch_predicted: 1'b0,
		long_latency: 1'b0
	};

	strand_oh_t strand_ready;
	strand_oh_t short_latency;
	strand_oh_t long_latency;
	strand_oh_t execute_hazard;
	strand_oh_t eligible;
	strand_oh_t grant;
	strand_idx_t grant_idx;
	lane_t reg_lane [NUM_STRANDS];
	offset_t strided_offset [NUM_STRANDS];

	always_comb
	begin
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			long_latency[i] = fetch_i[i].long_latency;
			short_latency[i] = fetch_i[i].valid && !fetch_i[i].long_latency
				&& fetch_i[i].instruction != INSTR_NOP;
		end
	end

	for (genvar s = 0; s < NUM_STRANDS; s++)
	begin : g_strand
		strand_fsm #(
			.LONG_STALL(LONG_STALL)
		) fsm (
			.clk(clk),
			.reset(reset),
			.fetch_i(fetch_i[s]),
			.ctrl_i(ctrl_i[s]),
			.grant_i(grant[s]),
			.ready_o(strand_ready[s]),
			.instruction_req_o(instruction_req_o[s]),
			.reg_lane_o(reg_lane[s]),
			.strided_offset_o(strided_offset[s])
		);
	end

	// Keep short ops away from the long pipeline's writeback slot
	execute_hazard_detect #(
		.NUM_STRANDS(NUM_STRANDS),
		.LONG_GAP(LONG_GAP)
	) hazard0 (
		.clk(clk),
		.reset(reset),
		.grant_i(grant),
		.short_latency_i(short_latency),
		.long_latency_i(long_latency),
		.hazard_o(execute_hazard)
	);

	assign eligible = strand_ready & strand_enable_i & ~execute_hazard;

	issue_arbiter #(
		.NUM_STRANDS(NUM_STRANDS)
	) arbiter0 (
		.clk(clk),
		.reset(reset),
		.request_i(eligible),
		.grant_o(grant)
	);

	// One-hot grant to index
	always_comb
	begin
		grant_idx = '0;
		for (int i = 0; i < NUM_STRANDS; i++)
			if (grant[i])
				grant_idx = strand_idx_t'(i);
	end

	// Issue register takes a NOP when nothing was granted
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			issue_o <= NOP_ISSUE;
		else if (grant != '0)
		begin
			issue_o <= '{
				pc: fetch_i[grant_idx].pc,
				instruction: fetch_i[grant_idx].instruction,
				reg_lane: reg_lane[grant_idx],
				strided_offset: strided_offset[grant_idx],
				strand: grant_idx,
				branch_predicted: fetch_i[grant_idx].branch_predicted,
				long_latency: fetch_i[grant_idx].long_latency
			};
		end
		else
			issue_o <= NOP_ISSUE;
	end

	// Enable, hazard and ready must all hold for the granted strand
	grant_is_eligible: assert property (
		@(posedge clk) disable iff (reset) (grant & ~eligible) == '0)
		else $error("strand_select_stage: grant to ineligible strand");

endmodule

`default_nettype wire

// File: verification/strand_select_tb.sv
/*
 * Testbench for the strand selection stage. Reads one cycle per line from
 * the vectors file, drives the fetch slots, control pulses and enable mask
 * on the falling edge and checks the request vector and the issue register.
 */
`timescale 1ns/1ps
`default_nettype none

module strand_select_tb
	import instruction_format_pkg::*;
	import strand_pkg::*;
;

	localparam int LONG_STALL = 4;
	localparam int LONG_GAP = 3;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 3;
	localparam int MARGIN_CYCLES = 20;
	localparam int MAX_VECTORS = 256;
	localparam int NUM_COLS = 20;

	// Column positions in the vectors file
	localparam int COL_EN = 0;
	localparam int COL_VALID = 1;
	localparam int COL_LL = 2;
	localparam int COL_BP = 3;
	localparam int COL_INSTR0 = 4;
	localparam int COL_ROLLBACK = 8;
	localparam int COL_RETRY = 9;
	localparam int COL_SUSPEND = 10;
	localparam int COL_RESUME = 11;
	localparam int COL_RB_LANE = 12;
	localparam int COL_RB_OFFSET = 13;
	localparam int COL_REQ = 14;
	localparam int COL_EXP_VALID = 15;
	localparam int COL_EXP_STRAND = 16;
	localparam int COL_EXP_LANE = 17;
	localparam int COL_EXP_OFFSET = 18;
	localparam int COL_EXP_LL = 19;

	logic clk;
	logic reset;
	strand_oh_t strand_enable;
	fetch_slot_t fetch [NUM_STRANDS];
	strand_ctrl_t ctrl [NUM_STRANDS];
	strand_oh_t instruction_req;
	issue_t issue;

	logic [31:0] vec [MAX_VECTORS][NUM_COLS];
	int line_no [MAX_VECTORS];
	int num_vectors;
	logic vectors_loaded;

	strand_select_stage #(
		.NUM_STRANDS(NUM_STRANDS),
		.LONG_STALL(LONG_STALL),
		.LONG_GAP(LONG_GAP)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.strand_enable_i(strand_enable),
		.fetch_i(fetch),
		.ctrl_i(ctrl),
		.instruction_req_o(instruction_req),
		.issue_o(issue)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	// Each strand fetches from its own code region
	function automatic addr_t pc_of(input int s);
		return addr_t'(32'h0000_1000 + s * 256);
	endfunction

	task automatic load_vectors();
		int fd;
		int r;
		string line;
		logic [31:0] f [NUM_COLS];

		num_vectors = 0;
		fd = $fopen("verification/strand_select_vectors.txt", "r");
		if (fd == 0)
			stop_on_failure("cannot open the vectors file");
		for (int n = 1; !$feof(fd); n++)
		begin
			r = $fgets(line, fd);
			if (r <= 0 || line.len() == 0 || line[0] == "#")
				continue;
			r = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
				f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
			if (r <= 0)
				continue;
			if (r != NUM_COLS)
				stop_on_failure($sformatf("vectors file line %0d has %0d columns", n, r));
			if (num_vectors == MAX_VECTORS)
				stop_on_failure("too many lines in the vectors file");
			for (int c = 0; c < NUM_COLS; c++)
				vec[num_vectors][c] = f[c];
			line_no[num_vectors] = n;
			num_vectors++;
		end
		$fclose(fd);
		if (num_vectors == 0)
			stop_on_failure("the vectors file holds no vectors");
	endtask

	task automatic apply_vector(input int k);
		strand_enable = vec[k][COL_EN][NUM_STRANDS-1:0];
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			fetch[s].instruction = vec[k][COL_INSTR0 + s];
			fetch[s].pc = pc_of(s);
			fetch[s].valid = vec[k][COL_VALID][s];
			fetch[s].branch_predicted = vec[k][COL_BP][s];
			fetch[s].long_latency = vec[k][COL_LL][s];
			ctrl[s].rollback = vec[k][COL_ROLLBACK][s];
			ctrl[s].retry = vec[k][COL_RETRY][s];
			ctrl[s].suspend = vec[k][COL_SUSPEND][s];
			ctrl[s].resume = vec[k][COL_RESUME][s];
			ctrl[s].rollback_lane = vec[k][COL_RB_LANE][3:0];
			ctrl[s].rollback_offset = vec[k][COL_RB_OFFSET];
		end
	endtask

	// Granted strand's fetch fields plus the lane state from the file
	function automatic issue_t expected_issue(input int k);
		issue_t exp;
		int s;

		exp = '0;
		if (vec[k][COL_EXP_VALID] != 0)
		begin
			s = int'(vec[k][COL_EXP_STRAND][1:0]);
			exp.pc = pc_of(s);
			exp.instruction = vec[k][COL_INSTR0 + s];
			exp.reg_lane = vec[k][COL_EXP_LANE][3:0];
			exp.strided_offset = vec[k][COL_EXP_OFFSET];
			exp.strand = strand_idx_t'(s);
			exp.branch_predicted = vec[k][COL_BP][s];
			exp.long_latency = vec[k][COL_EXP_LL][0];
		end
		return exp;
	endfunction

	task automatic check_issue(input string name, input issue_t exp, input issue_t act);
		if (act !== exp)
			stop_on_failure($sformatf("error %s issue expected %h actual %h", name, exp, act));
	endtask

	task automatic check_req(input string name, input strand_oh_t exp, input strand_oh_t act);
		if (act !== exp)
			stop_on_failure($sformatf("error %s request expected %h actual %h", name, exp, act));
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		strand_enable = '0;
		vectors_loaded = 1'b0;
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			fetch[s] = '0;
			ctrl[s] = '0;
		end

		load_vectors();
		vectors_loaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int k = 0; k < num_vectors; k++)
		begin
			apply_vector(k);
			#(CLK_PERIOD / 4);
			check_req($sformatf("vector line %0d", line_no[k]),
				vec[k][COL_REQ][NUM_STRANDS-1:0], instruction_req);
			@(posedge clk);
			#1;
			check_issue($sformatf("vector line %0d", line_no[k]), expected_issue(k), issue);
			@(negedge clk);
		end

		$display("Simulation passed");
		$finish;
	end

	// Run length follows from the number of vectors
	initial
	begin
		wait (vectors_loaded === 1'b1);
		#((num_vectors + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		stop_on_failure("watchdog expired before all vectors were applied");
	end

endmodule

`default_nettype wire

// File: verification/strand_select_vectors.txt
# en valid ll bp instr0 instr1 instr2 instr3 rollback retry suspend resume rb_lane rb_offset
#   exp_req exp_valid exp_strand exp_lane exp_offset exp_ll   (all hex, masks per strand)
0 F 0 0 11 22 33 44 0 0 0 0 0 0 0 0 0 0 0 0
0 F 0 0 11 22 33 44 0 0 0 0 0 0 0 0 0 0 0 0
0 F 0 0 11 22 33 44 0 0 0 0 0 0 0 0 0 0 0 0
F F 0 5 11 22 33 44 0 0 0 0 0 0 1 1 0 F 0 0
F F 0 5 11 22 33 44 0 0 0 0 0 0 2 1 1 F 0 0
F F 0 5 11 22 33 44 0 0 0 0 0 0 4 1 2 F 0 0
F F 0 5 11 22 33 44 0 0 0 0 0 0 8 1 3 F 0 0
F F 0 5 11 22 33 44 0 0 0 0 0 0 1 1 0 F 0 0
3 3 0 0 E0000008 22 0 0 0 0 0 0 0 0 2 1 1 F 0 0
3 3 0 0 E0000008 22 0 0 0 0 0 0 0 0 0 1 0 F 0 0
3 3 0 0 E0000008 22 0 0 0 0 0 0 0 0 2 1 1 F 0 0
3 3 0 0 E0000008 22 0 0 0 0 0 0 0 0 0 1 0 E 8 0
3 3 0 0 E0000008 22 0 0 0 0 0 0 0 0 2 1 1 F 0 0
3 3 0 0 E0000008 22 0 0 0 0 0 0 0 0 0 1 0 D 10 0
3 3 0 0 E0000008 22 0 0 0 0 0 0 0 0 2 1 1 F 0 0
3 3 0 0 E0000008 22 0 0 0 0 0 0 0 0 0 1 0 C 18 0
3 1 0 0 E0000008 22 0 0 0 0 0 0 0 0 0 1 0 B 20 0
3 1 0 0 E0000008 22 0 0 0 0 0 0 0 0 0 1 0 A 28 0
3 1 0 0 E0000008 22 0 0 0 0 0 0 0 0 0 1 0 9 30 0
3 1 0 0 E0000008 22 0 0 0 0 0 0 0 0 0 1 0 8 38 0
3 1 0 0 E0000008 22 0 0 0 0 0 0 0 0 0 1 0 7 40 0
3 1 0 0 E0000008 22 0 0 0 0 0 0 0 0 0 1 0 6 48 0
3 1 0 0 E0000008 22 0 0 0 0 0 0 0 0 0 1 0 5 50 0
3 1 0 0 E0000008 22 0 0 0 0 0 0 0 0 0 1 0 4 58 0
3 1 0 0 E0000008 22 0 0 0 0 0 0 0 0 0 1 0 3 60 0
3 1 0 0 E0000008 22 0 0 0 0 0 0 0 0 0 1 0 2 68 0
3 1 0 0 E0000008 22 0 0 0 0 0 0 0 0 0 1 0 1 70 0
3 1 0 0 E0000008 22 0 0 0 0 0 0 0 0 1 1 0 0 78 0
7 F 9 0 55 22 33 66 0 0 0 0 0 0 2 1 1 F 0 0
7 F 9 0 55 22 33 66 0 0 0 0 0 0 4 1 2 F 0 0
7 F 9 0 55 22 33 66 0 0 0 0 0 0 1 1 0 F 0 1
7 F 9 0 55 22 33 66 0 0 0 0 0 0 2 1 1 F 0 0
7 F 9 0 55 22 33 66 0 0 0 0 0 0 4 1 2 F 0 0
F F 9 0 55 22 33 66 0 0 0 0 0 0 8 1 3 F 0 1
F F 9 0 55 22 33 66 0 0 0 0 0 0 2 1 1 F 0 0
F F 9 0 55 22 33 66 0 0 0 0 0 0 4 1 2 F 0 0
F F 9 0 55 22 33 66 0 0 0 0 0 0 1 1 0 F 0 1
0 F 9 0 55 22 33 66 0 0 0 0 0 0 0 0 0 0 0 0
0 F 9 0 55 22 33 66 0 0 0 0 0 0 0 0 0 0 0 0
0 F 9 0 55 22 33 66 0 0 0 0 0 0 0 0 0 0 0 0
0 F 9 0 55 22 33 66 0 0 0 0 0 0 0 0 0 0 0 0
F 6 0 0 0 E0000004 33 0 0 0 4 0 0 0 0 1 1 F 0 0
F 6 0 0 0 E0000004 33 0 0 0 0 0 0 0 0 1 1 E 4 0
F 6 0 0 0 E0000004 33 0 0 0 0 0 0 0 0 1 1 D 8 0
F 6 0 0 0 E0000004 33 0 0 2 0 0 5 28 0 1 1 C C 0
F 6 0 0 0 E0000004 33 0 0 0 0 0 0 0 0 1 1 5 28 0
F 6 0 0 0 E0000004 33 0 0 0 0 4 0 0 0 1 1 4 2C 0
F 6 0 0 0 E0000004 33 0 0 0 0 0 0 0 4 1 2 F 0 0
F 6 0 0 0 E0000004 33 0 0 0 0 0 0 0 0 1 1 3 30 0
F 6 0 0 0 E0000004 33 0 2 0 0 0 0 0 4 1 2 F 0 0
F 6 0 0 0 E0000004 33 0 0 0 0 0 0 0 0 1 1 F 0 0
F 6 0 0 0 E0000004 33 0 0 0 0 0 0 0 4 1 2 F 0 0
F 6 0 0 0 E0000004 33 0 0 0 0 0 0 0 0 1 1 E 4 0

// File: vlog.f
source/instruction_format_pkg.sv
source/strand_pkg.sv
source/strand_fsm.sv
source/execute_hazard_detect.sv
source/issue_arbiter.sv
source/strand_select_stage.sv
verification/strand_select_tb.sv
